// ==== Bender.yml ====
package:
  name: approx_multiplier

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/approxMultPkg.sv
      - rtl/partialProductArray.sv
      - rtl/lowColumnCompressor.sv
      - rtl/highColumnCompressor.sv
      - rtl/koggeStoneAdder.sv
      - rtl/approxMultiplier.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/approxMultiplierTb.sv

// ==== approxMultiplier.f ====
+incdir+rtl
rtl/approxMultPkg.sv
rtl/partialProductArray.sv
rtl/lowColumnCompressor.sv
rtl/highColumnCompressor.sv
rtl/koggeStoneAdder.sv
rtl/approxMultiplier.sv
verif/approxMultiplierTb.sv

// ==== rtl/approxMultPkg.sv ====
`include "approxMult_consts.svh"

////////////////////////////////////////////////////////////////////
// Datapath vector types
////////////////////////////////////////////////////////////////////

package approxMultPkg;

    // One multiplicand or multiplier
    typedef logic [`OPERAND_WIDTH-1:0] operandT;

    // Full product, also each final row into the adder
    typedef logic [`PRODUCT_WIDTH-1:0] productT;

    // Partial products of one multiplier bit
    typedef logic [`OPERAND_WIDTH-1:0] ppRowT;

    // All eight rows, row i at bits [8i+7:8i]
    typedef logic [`OPERAND_WIDTH*`OPERAND_WIDTH-1:0] ppMatrixT;

    // One slot per mirrored pair i > j
    typedef logic [`OPERAND_WIDTH*(`OPERAND_WIDTH-1)/2-1:0] pairVecT;

endpackage

// ==== rtl/approxMult_consts.svh ====
`ifndef APPROX_MULT_CONSTS_SVH
`define APPROX_MULT_CONSTS_SVH

// Operand and product widths
`define OPERAND_WIDTH 8
`define PRODUCT_WIDTH 16

// Register stages between operand and product
`define PIPE_DEPTH 2

// Bit of partial product b[i] & a[j] in the flat matrix, weight i + j
`define PP_IDX(i, j) ((i) * `OPERAND_WIDTH + (j))

// Slot of mirrored pair (i, j) with i > j, packed row by row
`define PAIR_IDX(i, j) ((i) * ((i) - 1) / 2 + (j))

`endif

// ==== rtl/approxMultiplier.sv ====
`include "approxMult_consts.svh"

////////////////////////////////////////////////////////////////////
// Approximate 8x8 multiplier, two-stage valid/ready pipeline
////////////////////////////////////////////////////////////////////

module approxMultiplier (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inVal,
    output logic                   inRdy,
    input  approxMultPkg::operandT a,
    input  approxMultPkg::operandT b,
    output logic                   outVal,
    input  logic                   outRdy,
    output approxMultPkg::productT product
);

    // Partial products and pairs
    approxMultPkg::ppMatrixT ppMatrix;
    approxMultPkg::operandT  diag;
    approxMultPkg::pairVecT  pairProp;
    approxMultPkg::pairVecT  pairGen;

    // Row segments from both compressors
    approxMultPkg::ppRowT lowRowK, lowRowJ;
    approxMultPkg::ppRowT highRowK, highRowJ;
    logic [1:0]           carryIntoHigh;
    approxMultPkg::productT rowK, rowJ;

    // Stage one holds the rows
    logic                   s1Val;
    approxMultPkg::productT s1RowK, s1RowJ;
    approxMultPkg::productT sumRows;

    logic s2Free;
    logic inXfer;
    logic outXfer;

    // Operations between input and output handshake
    logic [1:0] inFlight;

    partialProductArray u_partialProductArray (
        .a        (a),
        .b        (b),
        .diag     (diag),
        .pairProp (pairProp),
        .pairGen  (pairGen),
        .ppMatrix (ppMatrix)
    );

    lowColumnCompressor u_lowColumnCompressor (
        .ppMatrix      (ppMatrix),
        .diag          (diag),
        .pairProp      (pairProp),
        .pairGen       (pairGen),
        .lowRowK       (lowRowK),
        .lowRowJ       (lowRowJ),
        .carryIntoHigh (carryIntoHigh)
    );

    highColumnCompressor u_highColumnCompressor (
        .ppMatrix      (ppMatrix),
        .diag          (diag),
        .pairProp      (pairProp),
        .pairGen       (pairGen),
        .carryIntoHigh (carryIntoHigh),
        .highRowK      (highRowK),
        .highRowJ      (highRowJ)
    );

    assign rowK = {highRowK, lowRowK};
    assign rowJ = {highRowJ, lowRowJ};

    // Adds the registered rows
    koggeStoneAdder u_koggeStoneAdder (
        .opA (s1RowK),
        .opB (s1RowJ),
        .sum (sumRows)
    );

    ////////////////////////////////////////////////////////////////////
    // Pipeline control
    ////////////////////////////////////////////////////////////////////

    // A stage loads when empty or when it drains on the same edge
    assign s2Free  = ~outVal | outRdy;
    assign inRdy   = ~s1Val | s2Free;
    assign inXfer  = inVal & inRdy;
    assign outXfer = outVal & outRdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1Val  <= 1'b0;
            outVal <= 1'b0;
        end else begin
            if (inRdy) begin
                s1Val <= inVal;
            end
            if (s2Free) begin
                outVal <= s1Val;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (inXfer) begin
            s1RowK <= rowK;
            s1RowJ <= rowJ;
        end
        if (s1Val && s2Free) begin
            product <= sumRows;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inFlight <= '0;
        end else begin
            inFlight <= inFlight + 2'(inXfer) - 2'(outXfer);
        end
    end

    // Output low right after reset
    assertResetOut: assert property (@(posedge clk) reset |=> !outVal);

    // Stalled result stays put
    assertStallStable: assert property (@(posedge clk) disable iff (reset)
        outVal && !outRdy |=> outVal && $stable(product));

    // Both slots taken by earlier handshakes and no drain, so no new input
    assertFullBlocks: assert property (@(posedge clk) disable iff (reset)
        (inFlight == `PIPE_DEPTH) && !outRdy |-> !inRdy);

endmodule

// ==== rtl/highColumnCompressor.sv ====
`include "approxMult_consts.svh"

////////////////////////////////////////////////////////////////////
// Exact reduction of columns 8 to 15
////////////////////////////////////////////////////////////////////

module highColumnCompressor (
    input  approxMultPkg::ppMatrixT ppMatrix,
    input  approxMultPkg::operandT  diag,
    input  approxMultPkg::pairVecT  pairProp,
    input  approxMultPkg::pairVecT  pairGen,
    input  logic [1:0]              carryIntoHigh,
    output approxMultPkg::ppRowT    highRowK,
    output approxMultPkg::ppRowT    highRowJ
);

    // Exact cells, all return {carry, sum}
    function automatic logic [1:0] halfAdd(input logic x, input logic y);
        halfAdd = {x & y, x ^ y};
    endfunction

    function automatic logic [1:0] fullAdd(input logic x, input logic y, input logic z);
        fullAdd = {(x & y) | (z & (x ^ y)), x ^ y ^ z};
    endfunction

    // 4:2 compressor from two full adders, returns {cout, carry, sum}
    function automatic logic [2:0] compress42(input logic x1, input logic x2, input logic x3,
                                              input logic x4, input logic cin);
        logic [1:0] first;
        logic [1:0] second;
        first      = fullAdd(x1, x2, x3);
        second     = fullAdd(first[0], x4, cin);
        compress42 = {first[1], second};
    endfunction

    // Propagate and generate column sums
    logic s8, s9, s10, s11, s12;
    logic g8, g9, g10, g11;

    // Compressor carries, one column up
    logic co8;
    logic [9:1] ce;

    // Resolved carries and the chain between them
    logic c8, c9, c10, c11, c12;
    logic [6:1] cer;

    logic [14:8] rowX;
    logic [14:9] rowY;

    ////////////////////////////////////////////////////////////////////
    // Column compression
    ////////////////////////////////////////////////////////////////////

    assign {co8, ce[1], s8} = compress42(pairProp[`PAIR_IDX(7, 1)], pairProp[`PAIR_IDX(6, 2)],
                                         pairProp[`PAIR_IDX(5, 3)], diag[4], 1'b0);
    assign {ce[2], g8} = fullAdd(pairGen[`PAIR_IDX(7, 1)], pairGen[`PAIR_IDX(6, 2)],
                                 pairGen[`PAIR_IDX(5, 3)]);
    assign {ce[3], s9} = fullAdd(pairProp[`PAIR_IDX(7, 2)], pairProp[`PAIR_IDX(6, 3)],
                                 pairProp[`PAIR_IDX(5, 4)]);
    assign {ce[4], g9} = fullAdd(pairGen[`PAIR_IDX(7, 2)], pairGen[`PAIR_IDX(6, 3)],
                                 pairGen[`PAIR_IDX(5, 4)]);
    assign {ce[5], s10} = fullAdd(pairProp[`PAIR_IDX(7, 3)], pairProp[`PAIR_IDX(6, 4)], diag[5]);
    assign {ce[6], g10} = halfAdd(pairGen[`PAIR_IDX(7, 3)], pairGen[`PAIR_IDX(6, 4)]);
    assign {ce[7], s11} = halfAdd(pairProp[`PAIR_IDX(7, 4)], pairProp[`PAIR_IDX(6, 5)]);
    assign {ce[8], g11} = halfAdd(pairGen[`PAIR_IDX(7, 4)], pairGen[`PAIR_IDX(6, 5)]);

    // Column 12 pair kept raw, its carry joins the chain at column 13
    assign {ce[9], s12} = halfAdd(ppMatrix[`PP_IDX(7, 5)], ppMatrix[`PP_IDX(5, 7)]);

    // Carry chain, one resolved carry per column
    assign {cer[1], c8}  = fullAdd(ce[1], ce[2], co8);
    assign {cer[2], c9}  = fullAdd(ce[3], ce[4], cer[1]);
    assign {cer[3], c10} = fullAdd(ce[5], ce[6], cer[2]);
    assign {cer[4], c11} = fullAdd(ce[7], ce[8], cer[3]);
    assign {cer[5], c12} = halfAdd(ce[9], cer[4]);

    ////////////////////////////////////////////////////////////////////
    // Row merge
    ////////////////////////////////////////////////////////////////////

    // PAC carry from column 7 enters here
    assign {rowY[9], rowX[8]}   = fullAdd(s8, g8, carryIntoHigh[0]);
    assign {rowY[10], rowX[9]}  = fullAdd(s9, g9, c8);
    assign {rowY[11], rowX[10]} = fullAdd(s10, g10, c9);
    assign {rowY[12], rowX[11]} = fullAdd(s11, g11, c10);
    assign {rowY[13], rowX[12]} = fullAdd(s12, c11, diag[6]);
    assign {rowY[14], rowX[13]} = fullAdd(ppMatrix[`PP_IDX(7, 6)], ppMatrix[`PP_IDX(6, 7)], c12);
    assign {cer[6], rowX[14]}   = halfAdd(diag[7], cer[5]);

    // Row-merge carry from column 7 sits in J at column 8
    assign highRowK = {cer[6], rowX[14:8]};
    assign highRowJ = {1'b0, rowY[14:9], carryIntoHigh[1]};

endmodule

// ==== rtl/koggeStoneAdder.sv ====
`include "approxMult_consts.svh"

////////////////////////////////////////////////////////////////////
// 16-bit Kogge-Stone prefix adder
////////////////////////////////////////////////////////////////////

module koggeStoneAdder (
    input  approxMultPkg::productT opA,
    input  approxMultPkg::productT opB,
    output approxMultPkg::productT sum
);

    // Four levels for span 1, 2, 4, 8
    localparam int Levels = 4;

    // Group generate per level, level 0 is bitwise
    logic [Levels:0][`PRODUCT_WIDTH-1:0]   gLvl;
    // Group propagate, last level needs none
    logic [Levels-1:0][`PRODUCT_WIDTH-1:0] pLvl;

    assign gLvl[0] = opA & opB;
    assign pLvl[0] = opA ^ opB;

    for (genvar lvl = 0; lvl < Levels; lvl++) begin : genLevel
        localparam int Span = 1 << lvl;

        for (genvar i = 0; i < `PRODUCT_WIDTH; i++) begin : genBit
            if (i < Span) begin : genPass
                // Group already reaches bit 0
                assign gLvl[lvl+1][i] = gLvl[lvl][i];
                if (lvl < Levels - 1) begin : genPassP
                    assign pLvl[lvl+1][i] = pLvl[lvl][i];
                end
            end else if (i < 2 * Span || lvl == Levels - 1) begin : genGrey
                // Grey cell, lower group is complete
                assign gLvl[lvl+1][i] = gLvl[lvl][i] | (pLvl[lvl][i] & gLvl[lvl][i-Span]);
                if (lvl < Levels - 1) begin : genGreyP
                    assign pLvl[lvl+1][i] = pLvl[lvl][i] & pLvl[lvl][i-Span];
                end
            end else begin : genBlack
                // Black cell, generate and propagate both combined
                assign gLvl[lvl+1][i] = gLvl[lvl][i] | (pLvl[lvl][i] & gLvl[lvl][i-Span]);
                assign pLvl[lvl+1][i] = pLvl[lvl][i] & pLvl[lvl][i-Span];
            end
        end
    end

    // Carry into bit i is the group generate of bits i-1 down to 0
    // Top group generate is the carry out, dropped
    assign sum = pLvl[0] ^ {gLvl[Levels][`PRODUCT_WIDTH-2:0], 1'b0};

endmodule

// ==== rtl/lowColumnCompressor.sv ====
`include "approxMult_consts.svh"

////////////////////////////////////////////////////////////////////
// Approximate reduction of columns 0 to 7
////////////////////////////////////////////////////////////////////

module lowColumnCompressor (
    input  approxMultPkg::ppMatrixT ppMatrix,
    input  approxMultPkg::operandT  diag,
    input  approxMultPkg::pairVecT  pairProp,
    input  approxMultPkg::pairVecT  pairGen,
    output approxMultPkg::ppRowT    lowRowK,
    output approxMultPkg::ppRowT    lowRowJ,
    output logic [1:0]              carryIntoHigh
);

    // OR half adder, returns {carry, sum}
    function automatic logic [1:0] approxHalf(input logic x, input logic y);
        approxHalf = {x & y, x | y};
    endfunction

    // First two inputs ORed before the carry stage
    function automatic logic [1:0] approxFull(input logic x, input logic y, input logic cin);
        logic w;
        w = x | y;
        approxFull = {w & cin, w ^ cin};
    endfunction

    // Four-input PAC cell, carry from the two AND pairs only
    function automatic logic [1:0] pacCell(input logic x1, input logic x2,
                                           input logic x3, input logic x4);
        logic c12;
        logic c34;
        c12 = x1 & x2;
        c34 = x3 & x4;
        pacCell = {c12 | c34, (x1 ^ x2) | (x3 ^ x4) | (c12 & c34)};
    endfunction

    // Column-stage sums and carries, carry has next column weight
    logic sum2, carry2;
    logic sum4, carry4;
    logic sum5, carry5;
    logic sum6, carry6;
    logic sum7, carry7;

    // Generates merged by OR per column
    logic [7:3] genMerge;

    // Row-merge outputs, X at column weight and Y one column up
    logic [7:3] rowX;
    logic [8:4] rowY;

    ////////////////////////////////////////////////////////////////////
    // Column compression
    ////////////////////////////////////////////////////////////////////

    // Column 2, raw b2a0 and b0a2
    assign {carry2, sum2} = approxHalf(ppMatrix[`PP_IDX(2, 0)], ppMatrix[`PP_IDX(0, 2)]);

    // Column 4
    assign {carry4, sum4} = approxHalf(pairProp[`PAIR_IDX(4, 0)], pairProp[`PAIR_IDX(3, 1)]);

    // Column 5
    assign {carry5, sum5} = approxFull(pairProp[`PAIR_IDX(5, 0)], pairProp[`PAIR_IDX(4, 1)],
                                       pairProp[`PAIR_IDX(3, 2)]);

    // Column 6, diagonal b3a3 fills the fourth PAC input
    assign {carry6, sum6} = pacCell(pairProp[`PAIR_IDX(6, 0)], pairProp[`PAIR_IDX(5, 1)],
                                    pairProp[`PAIR_IDX(4, 2)], diag[3]);

    // Column 7, its PAC carry lands in column 8
    assign {carry7, sum7} = pacCell(pairProp[`PAIR_IDX(7, 0)], pairProp[`PAIR_IDX(6, 1)],
                                    pairProp[`PAIR_IDX(5, 2)], pairProp[`PAIR_IDX(4, 3)]);

    assign genMerge[3] = pairGen[`PAIR_IDX(3, 0)] | pairGen[`PAIR_IDX(2, 1)];
    assign genMerge[4] = pairGen[`PAIR_IDX(4, 0)] | pairGen[`PAIR_IDX(3, 1)];
    assign genMerge[5] = pairGen[`PAIR_IDX(5, 0)] | pairGen[`PAIR_IDX(4, 1)]
                       | pairGen[`PAIR_IDX(3, 2)];
    assign genMerge[6] = pairGen[`PAIR_IDX(6, 0)] | pairGen[`PAIR_IDX(5, 1)]
                       | pairGen[`PAIR_IDX(4, 2)];
    assign genMerge[7] = pairGen[`PAIR_IDX(7, 0)] | pairGen[`PAIR_IDX(6, 1)]
                       | pairGen[`PAIR_IDX(5, 2)] | pairGen[`PAIR_IDX(4, 3)];

    ////////////////////////////////////////////////////////////////////
    // Fold each column into two rows
    ////////////////////////////////////////////////////////////////////

    assign {rowY[4], rowX[3]} = approxFull(pairProp[`PAIR_IDX(3, 0)], pairProp[`PAIR_IDX(2, 1)],
                                           genMerge[3]);
    assign {rowY[5], rowX[4]} = approxFull(sum4, diag[2], genMerge[4]);
    assign {rowY[6], rowX[5]} = approxFull(sum5, genMerge[5], carry4);
    assign {rowY[7], rowX[6]} = approxFull(sum6, genMerge[6], carry5);
    assign {rowY[8], rowX[7]} = approxFull(sum7, genMerge[7], carry6);

    // Columns 0 to 2 pass straight into the rows
    assign lowRowK = {rowX[7:3], sum2, ppMatrix[`PP_IDX(1, 0)], diag[0]};
    assign lowRowJ = {rowY[7:4], carry2, diag[1], ppMatrix[`PP_IDX(0, 1)], 1'b0};

    // Both at column-8 weight
    assign carryIntoHigh = {rowY[8], carry7};

endmodule

// ==== rtl/partialProductArray.sv ====
`include "approxMult_consts.svh"

////////////////////////////////////////////////////////////////////
// Partial products and mirrored pair reduction
////////////////////////////////////////////////////////////////////

module partialProductArray (
    input  approxMultPkg::operandT  a,
    input  approxMultPkg::operandT  b,
    output approxMultPkg::operandT  diag,
    output approxMultPkg::pairVecT  pairProp,
    output approxMultPkg::pairVecT  pairGen,
    output approxMultPkg::ppMatrixT ppMatrix
);

    // Row i is the multiplicand gated by multiplier bit i
    for (genvar i = 0; i < `OPERAND_WIDTH; i++) begin : genRow
        approxMultPkg::ppRowT rowBits;

        assign rowBits = a & {`OPERAND_WIDTH{b[i]}};
        assign ppMatrix[i*`OPERAND_WIDTH +: `OPERAND_WIDTH] = rowBits;

        // Square terms b[i] & a[i], no mirror partner
        assign diag[i] = rowBits[i];
    end

    ////////////////////////////////////////////////////////////////////
    // Pair (i, j) and (j, i) share column i + j
    ////////////////////////////////////////////////////////////////////

    for (genvar i = 1; i < `OPERAND_WIDTH; i++) begin : genPairRow
        for (genvar j = 0; j < i; j++) begin : genPairCol
            logic ppUpper;
            logic ppLower;

            assign ppUpper = ppMatrix[`PP_IDX(i, j)];
            assign ppLower = ppMatrix[`PP_IDX(j, i)];

            // OR plus AND equals the pair's arithmetic sum
            assign pairProp[`PAIR_IDX(i, j)] = ppUpper | ppLower;
            assign pairGen[`PAIR_IDX(i, j)]  = ppUpper & ppLower;
        end
    end

    // Swapping a and b only swaps ppUpper and ppLower
    // so every pair slot is symmetric in the operands

endmodule

// ==== verif/approxMultiplierTb.sv ====
`include "approxMult_consts.svh"

module approxMultiplierTb;

    localparam int DriveDelay    = 10;
    localparam int TimeoutCycles = 200;

    logic                   clk;
    logic                   reset;
    logic                   inVal;
    logic                   inRdy;
    approxMultPkg::operandT a;
    approxMultPkg::operandT b;
    logic                   outVal;
    logic                   outRdy;
    approxMultPkg::productT product;

    // Operands, expected products and received products
    approxMultPkg::operandT aQ[$];
    approxMultPkg::operandT bQ[$];
    approxMultPkg::productT expQ[$];
    approxMultPkg::productT resQ[$];

    // Handshake state sampled before the last edge
    logic                   seenIn;
    logic                   seenOut;
    logic                   seenInRdy;
    logic                   seenOutVal;
    approxMultPkg::productT seenProduct;

    logic [31:0] lfsrState;
    int          errorCount;
    int          timeoutCount;

    approxMultiplier u_approxMultiplier (
        .clk     (clk),
        .reset   (reset),
        .inVal   (inVal),
        .inRdy   (inRdy),
        .a       (a),
        .b       (b),
        .outVal  (outVal),
        .outRdy  (outRdy),
        .product (product)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // Random source and compare tasks
    ////////////////////////////////////////////////////////////////////

    // Galois LFSR, right shifting
    function automatic logic nextRandomBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    // Low bits filled, one LFSR step each
    function automatic approxMultPkg::operandT randomBits(input int width);
        approxMultPkg::operandT value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[`OPERAND_WIDTH-2:0], nextRandomBit()};
        end
        return value;
    endfunction

    task automatic checkProduct(input string name, input approxMultPkg::productT got,
                                input approxMultPkg::productT exp);
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %s got 0x%04h expected 0x%04h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////

    // Sample at the falling edge, then return just after the rising edge
    task automatic advanceCycle();
        @(negedge clk);
        seenInRdy   = inRdy;
        seenOutVal  = outVal;
        seenIn      = inVal && inRdy;
        seenOut     = outVal && outRdy;
        seenProduct = product;
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic clearQueues();
        aQ.delete();
        bQ.delete();
        expQ.delete();
        resQ.delete();
    endtask

    // 2^k times another operand is that operand shifted left by k
    task automatic queuePowerOfTwo(input int k, input approxMultPkg::operandT other,
                                   input bit swap);
        approxMultPkg::operandT pow;
        pow    = '0;
        pow[k] = 1'b1;
        aQ.push_back(swap ? other : pow);
        bQ.push_back(swap ? pow : other);
        expQ.push_back(approxMultPkg::productT'(other) << k);
    endtask

    // Sends from sendIdx on and collects until count results are in
    task automatic streamBatch(input int sendIdx, input int count, input bit checkSteady);
        int cycles;
        cycles = 0;
        while (resQ.size() < count && cycles < TimeoutCycles) begin
            inVal = (sendIdx < aQ.size());
            if (sendIdx < aQ.size()) begin
                a = aQ[sendIdx];
                b = bQ[sendIdx];
            end
            advanceCycle();
            cycles++;
            // Unstalled stream never drops inRdy or leaves a gap in outVal
            if (checkSteady && inVal) begin
                checkFlag("inRdy", seenInRdy, 1'b1);
            end
            if (checkSteady && resQ.size() > 0) begin
                checkFlag("outVal", seenOutVal, 1'b1);
            end
            if (seenIn) begin
                sendIdx++;
            end
            if (seenOut) begin
                resQ.push_back(seenProduct);
            end
        end
        inVal = 1'b0;
        if (resQ.size() < count) begin
            timeoutCount++;
            $display("Timeout: only %0d of %0d results arrived", resQ.size(), count);
        end
    endtask

    task automatic compareResults();
        for (int i = 0; i < expQ.size() && i < resQ.size(); i++) begin
            checkProduct($sformatf("product[%0d]", i), resQ[i], expQ[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////

    task automatic resetStateCheck();
        advanceCycle();
        checkFlag("outVal", seenOutVal, 1'b0);
        checkFlag("inRdy", seenInRdy, 1'b1);
    endtask

    // Lone nonzero term per column, so every cell is exact
    task automatic zeroAndPowerOfTwo();
        clearQueues();
        aQ.push_back('0);
        bQ.push_back(randomBits(8));
        expQ.push_back('0);
        aQ.push_back(randomBits(8));
        bQ.push_back('0);
        expQ.push_back('0);
        for (int k = 0; k < `OPERAND_WIDTH; k++) begin
            queuePowerOfTwo(k, randomBits(8), 1'b0);
            queuePowerOfTwo(k, randomBits(8), 1'b1);
        end
        streamBatch(0, aQ.size(), 1'b0);
        compareResults();
    endtask

    // Only columns 8 and up are populated
    task automatic highNibbleExact();
        approxMultPkg::operandT opA;
        approxMultPkg::operandT opB;
        clearQueues();
        for (int i = 0; i < 12; i++) begin
            opA = randomBits(4) << 4;
            opB = randomBits(4) << 4;
            aQ.push_back(opA);
            bQ.push_back(opB);
            expQ.push_back(approxMultPkg::productT'(opA) * approxMultPkg::productT'(opB));
        end
        streamBatch(0, aQ.size(), 1'b0);
        compareResults();
    endtask

    // Mirrored pairs treated alike, so the error is symmetric
    task automatic swappedOperands();
        approxMultPkg::operandT opA;
        approxMultPkg::operandT opB;
        clearQueues();
        for (int i = 0; i < 12; i++) begin
            opA = randomBits(8);
            opB = randomBits(8);
            aQ.push_back(opA);
            bQ.push_back(opB);
            aQ.push_back(opB);
            bQ.push_back(opA);
        end
        streamBatch(0, aQ.size(), 1'b0);
        for (int i = 0; 2 * i + 1 < resQ.size(); i++) begin
            checkProduct($sformatf("product[%0d] swapped", 2 * i + 1), resQ[2 * i + 1],
                         resQ[2 * i]);
        end
    endtask

    task automatic backPressureOrder();
        int accepted;
        int cycles;
        clearQueues();
        for (int i = 0; i < 4; i++) begin
            queuePowerOfTwo(randomBits(3), randomBits(8), i[0]);
        end
        // Fill both stages with the output blocked
        outRdy   = 1'b0;
        accepted = 0;
        cycles   = 0;
        while (accepted < 2 && cycles < TimeoutCycles) begin
            inVal = 1'b1;
            a     = aQ[accepted];
            b     = bQ[accepted];
            advanceCycle();
            cycles++;
            if (seenIn) begin
                accepted++;
            end
        end
        if (accepted < 2) begin
            timeoutCount++;
            $display("Timeout: pipeline did not accept two inputs under back-pressure");
        end
        a = aQ[2];
        b = bQ[2];
        // Full and stalled
        for (int i = 0; i < 4; i++) begin
            advanceCycle();
            checkFlag("inRdy", seenInRdy, 1'b0);
            checkFlag("outVal", seenOutVal, 1'b1);
            checkProduct("product", seenProduct, expQ[0]);
        end
        outRdy = 1'b1;
        streamBatch(2, aQ.size(), 1'b0);
        compareResults();
    endtask

    task automatic latencyAndThroughput();
        int cycles;
        int waited;
        clearQueues();
        queuePowerOfTwo(randomBits(3), randomBits(8), 1'b0);
        outRdy = 1'b1;
        inVal  = 1'b1;
        a      = aQ[0];
        b      = bQ[0];
        seenIn = 1'b0;
        cycles = 0;
        while (!seenIn && cycles < TimeoutCycles) begin
            advanceCycle();
            cycles++;
        end
        inVal = 1'b0;
        // outVal must rise exactly PIPE_DEPTH samples after the transfer
        seenOutVal = 1'b0;
        waited     = 0;
        while (!seenOutVal && waited < TimeoutCycles) begin
            advanceCycle();
            waited++;
            if (waited <= `PIPE_DEPTH) begin
                checkFlag("outVal", seenOutVal, waited == `PIPE_DEPTH);
            end
            if (seenOut) begin
                resQ.push_back(seenProduct);
            end
        end
        if (!seenOutVal) begin
            timeoutCount++;
            $display("Timeout: no result after a single input");
        end
        compareResults();
        // Back to back, one result per cycle
        clearQueues();
        for (int k = 0; k < `OPERAND_WIDTH; k++) begin
            queuePowerOfTwo(k, randomBits(8), k[0]);
        end
        streamBatch(0, aQ.size(), 1'b1);
        compareResults();
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        inVal        = 1'b0;
        a            = '0;
        b            = '0;
        outRdy       = 1'b1;
        lfsrState    = 32'h7046;
        errorCount   = 0;
        timeoutCount = 0;
        seenIn       = 1'b0;
        seenOut      = 1'b0;
        repeat (16) @(posedge clk);
        #DriveDelay;
        reset = 1'b0;

        resetStateCheck();
        zeroAndPowerOfTwo();
        highNibbleExact();
        swappedOperands();
        backPressureOrder();
        latencyAndThroughput();

        $display("Mismatches: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
